// File: compile.f
+incdir+verification
hw/alu_pkg.sv
hw/sequential_alu.sv
hw/alu_arbiter.sv
hw/wb_alu_port.sv
hw/alu_subsystem.sv
verification/alu_tb.sv

// File: hw/alu_arbiter.sv
module alu_arbiter import alu_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   // port side
   input  logic [1:0] i_req_valid,
   input  alu_req_t   i_req0,
   input  alu_req_t   i_req1,
   output logic [1:0] o_done,
   output alu_rsp_t   o_rsp,
   // alu side
   output logic       o_start,
   output alu_req_t   o_req,
   input  logic       i_busy,
   input  logic       i_done,
   input  alu_rsp_t   i_rsp
);

   logic [1:0] grant_q;
   // port that won the previous grant
   logic       last_q;
   logic       pick1;
   logic       launch;

   // port 1 wins when alone or when port 0 had the last turn
   assign pick1  = i_req_valid[1] & (~i_req_valid[0] | ~last_q);
   assign launch = (grant_q == 2'b00) & (|i_req_valid) & ~i_busy;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         grant_q <= 2'b00;
         last_q  <= 1'b1;
         o_start <= 1'b0;
      end else begin
         o_start <= launch;
         if (launch) begin
            grant_q <= pick1 ? 2'b10 : 2'b01;
            last_q  <= pick1;
         end else if (i_done) begin
            // free the alu once its job is done
            grant_q <= 2'b00;
         end
      end
   end

   // ports hold their request while granted
   assign o_req  = grant_q[1] ? i_req1 : i_req0;
   // done only to the winner
   assign o_done = grant_q & {2{i_done}};
   assign o_rsp  = i_rsp;

   // alu done only ever meets exactly one granted port
   a_grant_onehot: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_done |-> $onehot(grant_q));

endmodule

// File: hw/alu_pkg.sv
package alu_pkg;

   // operand and result width, fixed by the register layout
   localparam int DATA_WIDTH = 16;
   // wishbone data width
   localparam int BUS_WIDTH  = 32;
   // word address width of the port register map
   localparam int ADR_WIDTH  = 2;
   // divide step counter width
   localparam int CNT_WIDTH  = $clog2(DATA_WIDTH);

   // port register map, word offsets
   localparam logic [ADR_WIDTH-1:0] REG_OPERANDS = 2'd0;
   localparam logic [ADR_WIDTH-1:0] REG_COMMAND  = 2'd1;
   localparam logic [ADR_WIDTH-1:0] REG_RESULT   = 2'd2;

   // opcode, carried in bits 1..0 of a command write
   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2,
      OP_DIV = 2'd3
   } alu_op_e;

   // alu sequencer states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_ADDSUB,
      ST_MUL,
      ST_DIV,
      ST_SIGN
   } alu_state_e;

   // one job toward the alu
   typedef struct packed {
      alu_op_e                       op;
      logic signed [DATA_WIDTH-1:0] a;
      logic signed [DATA_WIDTH-1:0] b;
   } alu_req_t;

   // job result and flags
   typedef struct packed {
      logic signed [DATA_WIDTH-1:0] q;
      logic                          ovf;
      logic                          zero;
   } alu_rsp_t;

   // wishbone classic, host to port
   typedef struct packed {
      logic                 cyc;
      logic                 stb;
      logic                 we;
      logic [ADR_WIDTH-1:0] adr;
      logic [BUS_WIDTH-1:0] dat_w;
   } wb_m2s_t;

   // wishbone classic, port to host
   typedef struct packed {
      logic                 ack;
      logic [BUS_WIDTH-1:0] dat_r;
   } wb_s2m_t;

endpackage

// File: hw/alu_subsystem.sv
module alu_subsystem import alu_pkg::*; (
   input  logic    i_clk,
   input  logic    i_nrst,
   // host 0
   input  wb_m2s_t i_wb0,
   output wb_s2m_t o_wb0,
   // host 1
   input  wb_m2s_t i_wb1,
   output wb_s2m_t o_wb1
);

   // port to arbiter
   logic [1:0] req_valid;
   alu_req_t   req0;
   alu_req_t   req1;
   logic [1:0] port_done;
   alu_rsp_t   port_rsp;

   // arbiter to alu
   logic       alu_start;
   alu_req_t   alu_req;
   logic       alu_busy;
   logic       alu_done;
   alu_rsp_t   alu_rsp;

   wb_alu_port u_port0 (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_wb        (i_wb0),
      .o_wb        (o_wb0),
      .o_req_valid (req_valid[0]),
      .o_req       (req0),
      .i_done      (port_done[0]),
      .i_rsp       (port_rsp)
   );

   wb_alu_port u_port1 (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_wb        (i_wb1),
      .o_wb        (o_wb1),
      .o_req_valid (req_valid[1]),
      .o_req       (req1),
      .i_done      (port_done[1]),
      .i_rsp       (port_rsp)
   );

   alu_arbiter u_arbiter (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_req_valid (req_valid),
      .i_req0      (req0),
      .i_req1      (req1),
      .o_done      (port_done),
      .o_rsp       (port_rsp),
      .o_start     (alu_start),
      .o_req       (alu_req),
      .i_busy      (alu_busy),
      .i_done      (alu_done),
      .i_rsp       (alu_rsp)
   );

   sequential_alu u_alu (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_start     (alu_start),
      .i_req       (alu_req),
      .o_busy      (alu_busy),
      .o_done      (alu_done),
      .o_rsp       (alu_rsp)
   );

endmodule

// File: hw/sequential_alu.sv
module sequential_alu import alu_pkg::*; (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_start,
   input  alu_req_t i_req,
   output logic     o_busy,
   output logic     o_done,
   output alu_rsp_t o_rsp
);

   localparam int MSB = DATA_WIDTH - 1;

   // control state
   alu_state_e             state;
   alu_op_e                op_q;
   logic                   neg_q;
   logic [CNT_WIDTH-1:0]   cnt_q;

   // shared datapath registers
   // x: operand a, multiplier, dividend shifting into quotient
   // y: operand b, multiplicand, divisor
   // acc: product, remainder, final magnitude
   logic [DATA_WIDTH-1:0]  x_q;
   logic [DATA_WIDTH-1:0]  y_q;
   logic [DATA_WIDTH-1:0]  acc_q;

   // the single adder path
   logic [DATA_WIDTH-1:0]  add_a;
   logic [DATA_WIDTH-1:0]  add_b;
   logic                   add_cin;
   logic [DATA_WIDTH:0]    sum;

   logic                   add_ovf;
   logic [DATA_WIDTH-1:0]  rem_shift;
   logic                   trial_ok;
   logic                   mul_carry;
   logic                   mul_shift_ovf;
   logic                   sign_ovf;
   logic                   div_last;

   // absolute value, 0x8000 stays 0x8000 as unsigned
   function automatic logic [DATA_WIDTH-1:0] magnitude(input logic [DATA_WIDTH-1:0] v);
      return v[MSB] ? (~v + 1'b1) : v;
   endfunction

   // operand select per state
   always_comb begin
      add_a   = '0;
      add_b   = '0;
      add_cin = 1'b0;
      case (state)
         ST_ADDSUB: begin
            add_a   = x_q;
            // subtract as a + ~b + 1
            add_b   = (op_q == OP_SUB) ? ~y_q : y_q;
            add_cin = (op_q == OP_SUB);
         end
         ST_MUL: begin
            add_a = acc_q;
            add_b = y_q;
         end
         ST_DIV: begin
            // trial subtraction of the divisor
            add_a   = rem_shift;
            add_b   = ~y_q;
            add_cin = 1'b1;
         end
         ST_SIGN: begin
            // conditional negate of the magnitude
            add_a   = neg_q ? ~acc_q : acc_q;
            add_cin = neg_q;
         end
         default: ;
      endcase
   end

   assign sum = {1'b0, add_a} + {1'b0, add_b} + {{DATA_WIDTH{1'b0}}, add_cin};

   // signed overflow, like operand signs and a flipped result sign
   assign add_ovf       = (add_a[MSB] ~^ add_b[MSB]) & (sum[MSB] ^ add_a[MSB]);
   assign rem_shift     = {acc_q[MSB-1:0], x_q[MSB]};
   // carry out means no borrow
   assign trial_ok      = sum[DATA_WIDTH];
   assign mul_carry     = x_q[0] & sum[DATA_WIDTH];
   // multiplicand bit lost while multiplier bits remain
   assign mul_shift_ovf = y_q[MSB] & (x_q[MSB:1] != '0);
   // magnitude out of signed range for the result sign
   assign sign_ovf      = neg_q ? (acc_q[MSB] & (|acc_q[MSB-1:0])) : acc_q[MSB];
   assign div_last      = (cnt_q == CNT_WIDTH'(DATA_WIDTH - 1));

   assign o_busy = (state != ST_IDLE);

   // datapath
   always_ff @(posedge i_clk) begin
      case (state)
         ST_IDLE: begin
            if (i_start) begin
               if (i_req.op == OP_ADD || i_req.op == OP_SUB) begin
                  x_q <= i_req.a;
                  y_q <= i_req.b;
               end else begin
                  x_q <= magnitude(i_req.a);
                  y_q <= magnitude(i_req.b);
               end
               acc_q <= '0;
            end
         end
         ST_MUL: begin
            if (x_q[0]) begin
               acc_q <= sum[MSB:0];
            end
            x_q <= x_q >> 1;
            y_q <= y_q << 1;
         end
         ST_DIV: begin
            // last step parks the quotient in acc for the sign stage
            if (div_last) begin
               acc_q <= {x_q[MSB-1:0], trial_ok};
            end else if (trial_ok) begin
               acc_q <= sum[MSB:0];
            end else begin
               acc_q <= rem_shift;
            end
            x_q <= {x_q[MSB-1:0], trial_ok};
         end
         default: ;
      endcase
   end

   // sequencer
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= ST_IDLE;
         op_q   <= OP_ADD;
         neg_q  <= 1'b0;
         cnt_q  <= '0;
         o_done <= 1'b0;
         o_rsp  <= '0;
      end else begin
         o_done <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (i_start) begin
                  op_q  <= i_req.op;
                  neg_q <= i_req.a[MSB] ^ i_req.b[MSB];
                  cnt_q <= '0;
                  case (i_req.op)
                     OP_ADD, OP_SUB: state <= ST_ADDSUB;
                     OP_MUL:         state <= ST_MUL;
                     default: begin
                        // divide by zero ends before the loop
                        if (i_req.b == '0) begin
                           o_done <= 1'b1;
                           o_rsp  <= '{q: '0, ovf: 1'b0, zero: 1'b1};
                        end else begin
                           state <= ST_DIV;
                        end
                     end
                  endcase
               end
            end
            ST_ADDSUB: begin
               o_done <= 1'b1;
               o_rsp  <= '{q: sum[MSB:0], ovf: add_ovf, zero: 1'b0};
               state  <= ST_IDLE;
            end
            ST_MUL: begin
               if (x_q == '0) begin
                  state <= ST_SIGN;
               end else if (mul_carry || mul_shift_ovf) begin
                  o_done <= 1'b1;
                  o_rsp  <= '{q: '0, ovf: 1'b1, zero: 1'b0};
                  state  <= ST_IDLE;
               end
            end
            ST_DIV: begin
               cnt_q <= cnt_q + 1'b1;
               if (div_last) begin
                  state <= ST_SIGN;
               end
            end
            ST_SIGN: begin
               o_done <= 1'b1;
               o_rsp  <= '{q: sign_ovf ? '0 : sum[MSB:0], ovf: sign_ovf, zero: 1'b0};
               state  <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // arbiter must wait for idle
   a_no_start_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_start |-> !o_busy);

   // done is a single pulse
   a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_done |=> !o_done);

endmodule

// File: hw/wb_alu_port.sv
module wb_alu_port import alu_pkg::*; (
   input  logic     i_clk,
   input  logic     i_nrst,
   // wishbone classic slave
   input  wb_m2s_t  i_wb,
   output wb_s2m_t  o_wb,
   // toward the arbiter
   output logic     o_req_valid,
   output alu_req_t o_req,
   input  logic     i_done,
   input  alu_rsp_t i_rsp
);

   logic                          ack_q;
   logic                          access;
   logic [BUS_WIDTH-1:0]          rdata;
   // last result and flags
   alu_rsp_t                      res_q;
   // operand and opcode holding registers
   logic signed [DATA_WIDTH-1:0]  a_q;
   logic signed [DATA_WIDTH-1:0]  b_q;
   alu_op_e                       op_q;

   // new bus access, not yet acked and no job pending
   assign access = i_wb.cyc & i_wb.stb & ~ack_q & ~o_req_valid;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         ack_q       <= 1'b0;
         o_req_valid <= 1'b0;
         res_q       <= '0;
      end else begin
         ack_q <= 1'b0;
         if (o_req_valid) begin
            // command cycle stays stalled until the job returns
            if (i_done) begin
               o_req_valid <= 1'b0;
               res_q       <= i_rsp;
               ack_q       <= 1'b1;
            end
         end else if (access) begin
            if (i_wb.we && i_wb.adr == REG_COMMAND) begin
               o_req_valid <= 1'b1;
            end else begin
               // operands, result read and unmapped offsets
               ack_q <= 1'b1;
            end
         end
      end
   end

   // operand and opcode capture
   always_ff @(posedge i_clk) begin
      if (access && i_wb.we) begin
         case (i_wb.adr)
            REG_OPERANDS: begin
               a_q <= i_wb.dat_w[BUS_WIDTH-1:DATA_WIDTH];
               b_q <= i_wb.dat_w[DATA_WIDTH-1:0];
            end
            REG_COMMAND: op_q <= alu_op_e'(i_wb.dat_w[1:0]);
            default: ;
         endcase
      end
   end

   assign o_req = '{op: op_q, a: a_q, b: b_q};

   // result word is zero, ovf, q in the low bits
   always_comb begin
      rdata = '0;
      if (i_wb.adr == REG_RESULT) begin
         rdata = {{(BUS_WIDTH - DATA_WIDTH - 2){1'b0}}, res_q.zero, res_q.ovf, res_q.q};
      end
   end

   assign o_wb = '{ack: ack_q, dat_r: rdata};

   // host keeps its cycle up until ack
   a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_wb.ack |-> (i_wb.cyc && i_wb.stb));

endmodule

// File: verification/alu_tb_table.svh
// columns: port, opcode, a, b, expected q, expected ovf, expected zero
// a, b and q are signed decimal, flags are single bits
typedef struct packed {
   logic                          port;
   alu_op_e                       op;
   logic signed [DATA_WIDTH-1:0]  a;
   logic signed [DATA_WIDTH-1:0]  b;
   logic signed [DATA_WIDTH-1:0]  q;
   logic                          ovf;
   logic                          zero;
} vec_row_t;

localparam int N_ROWS = 30;

localparam vec_row_t VECTORS [N_ROWS] = '{
   // add, wrap on both overflow sides
   '{1'b0, OP_ADD,    100,   -300,   -200, 1'b0, 1'b0},
   '{1'b1, OP_ADD,  32767,      1, -32768, 1'b1, 1'b0},
   '{1'b0, OP_ADD, -32768,     -1,  32767, 1'b1, 1'b0},
   '{1'b1, OP_ADD, -20000, -12768, -32768, 1'b0, 1'b0},
   // subtract, including -32768 as subtrahend
   '{1'b0, OP_SUB,      5,     12,     -7, 1'b0, 1'b0},
   '{1'b1, OP_SUB,      0, -32768, -32768, 1'b1, 1'b0},
   '{1'b0, OP_SUB,     -1, -32768,  32767, 1'b0, 1'b0},
   '{1'b1, OP_SUB,  32767,     -1, -32768, 1'b1, 1'b0},
   '{1'b0, OP_SUB, -32768,      1,  32767, 1'b1, 1'b0},
   // multiply, all four sign combinations
   '{1'b0, OP_MUL,    123,     45,   5535, 1'b0, 1'b0},
   '{1'b1, OP_MUL,   -123,     45,  -5535, 1'b0, 1'b0},
   '{1'b0, OP_MUL,    123,    -45,  -5535, 1'b0, 1'b0},
   '{1'b1, OP_MUL,   -123,    -45,   5535, 1'b0, 1'b0},
   // +32768 does not fit, -32768 does
   '{1'b0, OP_MUL,    256,    128,      0, 1'b1, 1'b0},
   '{1'b1, OP_MUL,   -256,    128, -32768, 1'b0, 1'b0},
   '{1'b0, OP_MUL,   -256,   -128,      0, 1'b1, 1'b0},
   '{1'b1, OP_MUL,    300,    300,      0, 1'b1, 1'b0},
   '{1'b0, OP_MUL,      0, -32768,      0, 1'b0, 1'b0},
   '{1'b1, OP_MUL,    181,    181,  32761, 1'b0, 1'b0},
   '{1'b0, OP_MUL, -32768,     -1,      0, 1'b1, 1'b0},
   // divide, truncation toward zero
   '{1'b0, OP_DIV,    100,      7,     14, 1'b0, 1'b0},
   '{1'b1, OP_DIV,   -100,      7,    -14, 1'b0, 1'b0},
   '{1'b0, OP_DIV,    100,     -7,    -14, 1'b0, 1'b0},
   '{1'b1, OP_DIV,   -100,     -7,     14, 1'b0, 1'b0},
   '{1'b0, OP_DIV,      7,    100,      0, 1'b0, 1'b0},
   '{1'b1, OP_DIV,   1234,      0,      0, 1'b0, 1'b1},
   '{1'b0, OP_DIV, -32768,     -1,      0, 1'b1, 1'b0},
   '{1'b1, OP_DIV, -32768,      1, -32768, 1'b0, 1'b0},
   '{1'b0, OP_DIV,  32767,     -1, -32767, 1'b0, 1'b0},
   '{1'b1, OP_DIV,     -7,      2,     -3, 1'b0, 1'b0}
};

// File: verification/alu_tb.sv
module alu_tb import alu_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   `include "alu_tb_table.svh"

   // one job per port in each random pair
   localparam int N_RAND_PAIRS   = 12;
   localparam int N_JOBS         = N_ROWS + 2 * N_RAND_PAIRS;
   // up to 40 cycles for each of two bus phases per job
   localparam int TIMEOUT_CYCLES = N_JOBS * 2 * 40;
   // signed result range
   localparam int Q_MAX          = 2 ** (DATA_WIDTH - 1) - 1;
   localparam int Q_MIN          = -(2 ** (DATA_WIDTH - 1));

   logic    clk;
   logic    nrst;
   wb_m2s_t wb_m2s [2];
   wb_s2m_t wb_s2m [2];

   integer  seed      = 63672;
   int      errors    = 0;
   int      checks    = 0;
   int      cycle_cnt = 0;

   logic [BUS_WIDTH-1:0]         word;
   vec_row_t                     row;
   alu_rsp_t                     exp_rsp;
   // last result each port should still hold
   alu_rsp_t                     last_rsp  [2];
   alu_op_e                      rand_op   [2];
   logic signed [DATA_WIDTH-1:0] rand_a    [2];
   logic signed [DATA_WIDTH-1:0] rand_b    [2];
   logic [BUS_WIDTH-1:0]         rand_word [2];

   alu_subsystem dut0 (
      .i_clk  (clk),
      .i_nrst (nrst),
      .i_wb0  (wb_m2s[0]),
      .o_wb0  (wb_s2m[0]),
      .i_wb1  (wb_m2s[1]),
      .o_wb1  (wb_s2m[1])
   );

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // one classic cycle held until ack
   task automatic bus_cycle(input int port, input logic we, input logic [ADR_WIDTH-1:0] adr,
                            input logic [BUS_WIDTH-1:0] wdata,
                            output logic [BUS_WIDTH-1:0] rdata);
      @(posedge clk);
      wb_m2s[port] <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
      // ack and data looked at on the falling edge
      do begin
         @(negedge clk);
      end while (!wb_s2m[port].ack);
      rdata = wb_s2m[port].dat_r;
      @(posedge clk);
      wb_m2s[port] <= '0;
   endtask

   task automatic write_operands(input int port, input logic [DATA_WIDTH-1:0] a,
                                 input logic [DATA_WIDTH-1:0] b);
      logic [BUS_WIDTH-1:0] unused;
      bus_cycle(port, 1'b1, REG_OPERANDS, {a, b}, unused);
   endtask

   // ack comes back only when the job is done
   task automatic write_command(input int port, input alu_op_e op);
      logic [BUS_WIDTH-1:0] unused;
      bus_cycle(port, 1'b1, REG_COMMAND, BUS_WIDTH'(op), unused);
   endtask

   task automatic read_result(input int port, output logic [BUS_WIDTH-1:0] rdata);
      bus_cycle(port, 1'b0, REG_RESULT, '0, rdata);
   endtask

   task automatic run_job(input int port, input alu_op_e op, input logic [DATA_WIDTH-1:0] a,
                          input logic [DATA_WIDTH-1:0] b, output logic [BUS_WIDTH-1:0] rdata);
      write_operands(port, a, b);
      write_command(port, op);
      read_result(port, rdata);
   endtask

   // result word holds 14 zero bits then zero, ovf and q
   task automatic check_result(input int port, input alu_rsp_t exp,
                               input logic [BUS_WIDTH-1:0] got, input string what);
      checks++;
      if (got[DATA_WIDTH-1:0] !== exp.q) begin
         errors++;
         $display("** Error at %0t: %s port%0d q expected %0d, got %0d", $time, what, port,
                  exp.q, $signed(got[DATA_WIDTH-1:0]));
      end
      if (got[DATA_WIDTH] !== exp.ovf) begin
         errors++;
         $display("** Error at %0t: %s port%0d ovf expected %b, got %b", $time, what, port,
                  exp.ovf, got[DATA_WIDTH]);
      end
      if (got[DATA_WIDTH+1] !== exp.zero) begin
         errors++;
         $display("** Error at %0t: %s port%0d zero expected %b, got %b", $time, what, port,
                  exp.zero, got[DATA_WIDTH+1]);
      end
      if (got[BUS_WIDTH-1:DATA_WIDTH+2] !== '0) begin
         errors++;
         $display("** Error at %0t: %s port%0d dat_r upper bits expected 0, got %h", $time,
                  what, port, got[BUS_WIDTH-1:DATA_WIDTH+2]);
      end
   endtask

   // reference model of the signed alu result and flags
   function automatic alu_rsp_t model_alu(input alu_op_e op, input logic signed [15:0] a,
                                          input logic signed [15:0] b);
      int       exact;
      alu_rsp_t r;
      r     = '0;
      exact = 0;
      case (op)
         OP_ADD, OP_SUB, OP_MUL: begin
            if (op == OP_ADD) exact = int'(a) + int'(b);
            else if (op == OP_SUB) exact = int'(a) - int'(b);
            else exact = int'(a) * int'(b);
            r.ovf = (exact > Q_MAX) || (exact < Q_MIN);
            // add and sub wrap while an oversized product reads as 0
            r.q   = (op == OP_MUL && r.ovf) ? '0 : exact[DATA_WIDTH-1:0];
         end
         default: begin
            if (b == 0) r.zero = 1'b1;
            else if (a == Q_MIN && b == -1) r.ovf = 1'b1;
            else begin
               exact = int'(a) / int'(b);
               r.q   = exact[DATA_WIDTH-1:0];
            end
         end
      endcase
      return r;
   endfunction

   // full-range value shifted down by a random amount so 0 and -1 stay common
   function automatic logic signed [DATA_WIDTH-1:0] random_operand();
      logic signed [DATA_WIDTH-1:0] v;
      int                           sh;
      v  = $random(seed);
      sh = $random(seed) & 15;
      return v >>> sh;
   endfunction

   initial begin
      nrst      = 1'b0;
      wb_m2s[0] = '0;
      wb_m2s[1] = '0;
      repeat (3) @(posedge clk);
      nrst <= 1'b1;
      // both result registers start cleared
      for (int p = 0; p < 2; p++) begin
         read_result(p, word);
         check_result(p, '0, word, "after reset");
         last_rsp[p] = '0;
      end
      // table rows followed by a look at the idle port
      for (int i = 0; i < N_ROWS; i++) begin
         row     = VECTORS[i];
         exp_rsp = '{q: row.q, ovf: row.ovf, zero: row.zero};
         run_job(row.port, row.op, row.a, row.b, word);
         check_result(row.port, exp_rsp, word, $sformatf("row %0d", i));
         last_rsp[row.port] = exp_rsp;
         // the other port must still hold its own last result
         read_result(!row.port, word);
         check_result(!row.port, last_rsp[!row.port], word, $sformatf("row %0d held", i));
      end
      // both ports fire together and contend for the alu
      for (int k = 0; k < N_RAND_PAIRS; k++) begin
         for (int p = 0; p < 2; p++) begin
            rand_op[p] = alu_op_e'(2'($random(seed)));
            rand_a[p]  = random_operand();
            rand_b[p]  = random_operand();
         end
         fork
            run_job(0, rand_op[0], rand_a[0], rand_b[0], rand_word[0]);
            run_job(1, rand_op[1], rand_a[1], rand_b[1], rand_word[1]);
         join
         for (int p = 0; p < 2; p++) begin
            check_result(p, model_alu(rand_op[p], rand_a[p], rand_b[p]), rand_word[p],
                         $sformatf("random %0d %s %0d %0d", k, rand_op[p].name(), rand_a[p],
                                   rand_b[p]));
         end
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // watchdog that ends a stalled bus cycle
   initial begin
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Errors found");
      $finish;
   end

endmodule
